//--- include/dm_bus_settings.svh
`ifndef DM_BUS_SETTINGS_SVH
`define DM_BUS_SETTINGS_SVH

// data path width in bits.
`define DM_DW 32

// byte address width.
`define DM_AW 32

// local sram depth in words.
`define DM_SRAM_WORDS 256

// byte address of the first sram word.
`define DM_SRAM_BASE 32'h0000_0000

// core data ports plus message adapter.
// the arbiter fsm is written for exactly three.
`define DM_NUM_MASTERS 3

`endif

//--- hw/dm_bus_pkg.sv
`include "dm_bus_settings.svh"

package dm_bus_pkg;

   // one bus data word.
   typedef logic [`DM_DW-1:0] dm_data_t;

   // byte address as issued by a master.
   typedef logic [`DM_AW-1:0] dm_addr_t;

   // one select bit per byte lane.
   typedef logic [`DM_DW/8-1:0] dm_sel_t;

   // index of the master that owns the bus.
   typedef logic [1:0] dm_gnt_t;

   // arbiter states, encoded so that the state is the grant.
   typedef enum logic [1:0] {
      grant0 = 2'd0,
      grant1 = 2'd1,
      grant2 = 2'd2
   } dm_arb_state_e;

endpackage

//--- hw/dm_bus_arbiter.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_bus_arbiter (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [`DM_NUM_MASTERS-1:0] req, // cyc of each master.
   output dm_bus_pkg::dm_gnt_t        gnt
);

   dm_bus_pkg::dm_arb_state_e state;
   dm_bus_pkg::dm_arb_state_e state_nxt;

   assign gnt = dm_bus_pkg::dm_gnt_t'(state); // state doubles as grant.

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= dm_bus_pkg::grant0; // master 0 owns the bus after reset.
      end else begin
         state <= state_nxt;
      end
   end

   // owner keeps the bus while its cyc is up.
   // on release, search cyclically starting after the owner.
   always_comb begin
      state_nxt = state;
      case (state)
         dm_bus_pkg::grant0: begin
            if (!req[0]) begin
               if (req[1]) state_nxt = dm_bus_pkg::grant1;
               else if (req[2]) state_nxt = dm_bus_pkg::grant2;
            end
         end
         dm_bus_pkg::grant1: begin
            if (!req[1]) begin
               if (req[2]) state_nxt = dm_bus_pkg::grant2;
               else if (req[0]) state_nxt = dm_bus_pkg::grant0;
            end
         end
         dm_bus_pkg::grant2: begin
            if (!req[2]) begin
               if (req[0]) state_nxt = dm_bus_pkg::grant0;
               else if (req[1]) state_nxt = dm_bus_pkg::grant1;
            end
         end
         default: begin
            state_nxt = dm_bus_pkg::grant0; // recover from the spare code.
         end
      endcase
   end

   // encoding 3 has no master behind it.
   a_state_legal: assert property (@(posedge clk) disable iff (rst)
      gnt != 2'd3);

endmodule

//--- hw/dm_bus_mux.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_bus_mux (
   // master side.
   input  logic [`DM_NUM_MASTERS-1:0] m_cyc,
   input  logic [`DM_NUM_MASTERS-1:0] m_stb,
   input  logic [`DM_NUM_MASTERS-1:0] m_we,
   input  dm_bus_pkg::dm_sel_t        m_sel [`DM_NUM_MASTERS],
   input  dm_bus_pkg::dm_addr_t       m_adr [`DM_NUM_MASTERS],
   input  dm_bus_pkg::dm_data_t       m_dat_w [`DM_NUM_MASTERS],
   output dm_bus_pkg::dm_data_t       m_dat_r,
   output logic [`DM_NUM_MASTERS-1:0] m_ack,
   output logic [`DM_NUM_MASTERS-1:0] m_err,
   // owner from the arbiter.
   input  dm_bus_pkg::dm_gnt_t        gnt,
   // shared bus side.
   output logic                       bus_cyc,
   output logic                       bus_stb,
   output logic                       bus_we,
   output dm_bus_pkg::dm_sel_t        bus_sel,
   output dm_bus_pkg::dm_addr_t       bus_adr,
   output dm_bus_pkg::dm_data_t       bus_dat_w,
   input  dm_bus_pkg::dm_data_t       bus_dat_r,
   input  logic                       bus_ack,
   input  logic                       bus_err
);

   // request path, straight copy of the owner.
   always_comb begin
      bus_cyc   = m_cyc[gnt];
      bus_stb   = m_stb[gnt];
      bus_we    = m_we[gnt];
      bus_sel   = m_sel[gnt];
      bus_adr   = m_adr[gnt];
      bus_dat_w = m_dat_w[gnt];
   end

   // read data goes to everyone.
   // only the acked master takes it.
   assign m_dat_r = bus_dat_r;

   // response path, owner only.
   always_comb begin
      m_ack = '0;
      m_err = '0;
      for (int i = 0; i < `DM_NUM_MASTERS; i++) begin
         if (gnt == dm_bus_pkg::dm_gnt_t'(i)) begin
            m_ack[i] = bus_ack;
            m_err[i] = bus_err;
         end
      end
      // a second acked master would mean the grant decode is broken.
      a_ack_onehot: assert ($onehot0(m_ack));
   end

endmodule

//--- hw/dm_bus_decode.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_bus_decode (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 bus_cyc,
   input  logic                                 bus_stb,
   input  logic                                 bus_we,
   input  dm_bus_pkg::dm_sel_t                  bus_sel,
   input  dm_bus_pkg::dm_addr_t                 bus_adr,
   input  dm_bus_pkg::dm_data_t                 bus_dat_w,
   output dm_bus_pkg::dm_data_t                 bus_dat_r,
   output logic                                 bus_ack,
   output logic                                 bus_err,
   output logic                                 ram_stb,
   output logic                                 ram_we,
   output dm_bus_pkg::dm_sel_t                  ram_sel,
   output logic [$clog2(`DM_SRAM_WORDS)-1:0]    ram_word,
   output dm_bus_pkg::dm_data_t                 ram_dat_w,
   input  dm_bus_pkg::dm_data_t                 ram_dat_r,
   input  logic                                 ram_ack
);

   dm_bus_pkg::dm_addr_t offset; // byte offset into the sram window.
   logic                 hit;
   logic                 err_q;  // error responder.

   assign offset = bus_adr - `DM_SRAM_BASE;
   assign hit    = offset < `DM_AW'(`DM_SRAM_WORDS * (`DM_DW / 8));

   // hits go straight through.
   assign ram_stb   = bus_cyc & bus_stb & hit;
   assign ram_we    = bus_we;
   assign ram_sel   = bus_sel;
   assign ram_word  = offset[$clog2(`DM_SRAM_WORDS)+1:2]; // drop byte bits.
   assign ram_dat_w = bus_dat_w;

   // misses get err one cycle later, once per access.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= bus_cyc & bus_stb & ~hit & ~err_q;
      end
   end

   assign bus_ack   = ram_ack;
   assign bus_err   = err_q;
   assign bus_dat_r = err_q ? '0 : ram_dat_r; // no stale data on err.

   // sram and error responder must never answer the same access.
   a_ack_err_excl: assert property (@(posedge clk) disable iff (rst)
      !(bus_ack && bus_err));

endmodule

//--- hw/dm_sram.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_sram (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              ram_stb,
   input  logic                              ram_we,
   input  dm_bus_pkg::dm_sel_t               ram_sel,
   input  logic [$clog2(`DM_SRAM_WORDS)-1:0] ram_word,
   input  dm_bus_pkg::dm_data_t              ram_dat_w,
   output dm_bus_pkg::dm_data_t              ram_dat_r,
   output logic                              ram_ack
);

   dm_bus_pkg::dm_data_t mem [`DM_SRAM_WORDS];
   logic                 take; // access accepted this cycle.

   // stb stays up during the ack cycle, skip it there.
   assign take = ram_stb & ~ram_ack;

   // ack follows stb by one cycle.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ram_ack <= 1'b0;
      end else begin
         ram_ack <= take;
      end
   end

   // byte lane writes.
   always_ff @(posedge clk) begin
      if (take && ram_we) begin
         for (int b = 0; b < `DM_DW / 8; b++) begin
            if (ram_sel[b]) begin
               mem[ram_word][b*8 +: 8] <= ram_dat_w[b*8 +: 8];
            end
         end
      end
   end

   // read data lands together with ack.
   // on a write it shows the old word.
   always_ff @(posedge clk) begin
      if (take) begin
         ram_dat_r <= mem[ram_word];
      end
   end

   // one ack per access even with stb held.
   a_single_ack: assert property (@(posedge clk) disable iff (rst)
      ram_ack |=> !ram_ack);

endmodule

//--- hw/dm_bus_top.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_bus_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [`DM_NUM_MASTERS-1:0] m_cyc,
   input  logic [`DM_NUM_MASTERS-1:0] m_stb,
   input  logic [`DM_NUM_MASTERS-1:0] m_we,
   input  dm_bus_pkg::dm_sel_t        m_sel [`DM_NUM_MASTERS],
   input  dm_bus_pkg::dm_addr_t       m_adr [`DM_NUM_MASTERS],
   input  dm_bus_pkg::dm_data_t       m_dat_w [`DM_NUM_MASTERS],
   output dm_bus_pkg::dm_data_t       m_dat_r,
   output logic [`DM_NUM_MASTERS-1:0] m_ack,
   output logic [`DM_NUM_MASTERS-1:0] m_err
);

   dm_bus_pkg::dm_gnt_t                gnt;
   logic                               bus_cyc;
   logic                               bus_stb;
   logic                               bus_we;
   dm_bus_pkg::dm_sel_t                bus_sel;
   dm_bus_pkg::dm_addr_t               bus_adr;
   dm_bus_pkg::dm_data_t               bus_dat_w;
   dm_bus_pkg::dm_data_t               bus_dat_r;
   logic                               bus_ack;
   logic                               bus_err;
   logic                               ram_stb;
   logic                               ram_we;
   dm_bus_pkg::dm_sel_t                ram_sel;
   logic [$clog2(`DM_SRAM_WORDS)-1:0]  ram_word;
   dm_bus_pkg::dm_data_t               ram_dat_w;
   dm_bus_pkg::dm_data_t               ram_dat_r;
   logic                               ram_ack;

   // cyc is the bus request.
   dm_bus_arbiter dm_bus_arbiter_i (
      .clk (clk),
      .rst (rst),
      .req (m_cyc),
      .gnt (gnt)
   );

   dm_bus_mux dm_bus_mux_i (
      .m_cyc     (m_cyc),
      .m_stb     (m_stb),
      .m_we      (m_we),
      .m_sel     (m_sel),
      .m_adr     (m_adr),
      .m_dat_w   (m_dat_w),
      .m_dat_r   (m_dat_r),
      .m_ack     (m_ack),
      .m_err     (m_err),
      .gnt       (gnt),
      .bus_cyc   (bus_cyc),
      .bus_stb   (bus_stb),
      .bus_we    (bus_we),
      .bus_sel   (bus_sel),
      .bus_adr   (bus_adr),
      .bus_dat_w (bus_dat_w),
      .bus_dat_r (bus_dat_r),
      .bus_ack   (bus_ack),
      .bus_err   (bus_err)
   );

   dm_bus_decode dm_bus_decode_i (
      .clk       (clk),
      .rst       (rst),
      .bus_cyc   (bus_cyc),
      .bus_stb   (bus_stb),
      .bus_we    (bus_we),
      .bus_sel   (bus_sel),
      .bus_adr   (bus_adr),
      .bus_dat_w (bus_dat_w),
      .bus_dat_r (bus_dat_r),
      .bus_ack   (bus_ack),
      .bus_err   (bus_err),
      .ram_stb   (ram_stb),
      .ram_we    (ram_we),
      .ram_sel   (ram_sel),
      .ram_word  (ram_word),
      .ram_dat_w (ram_dat_w),
      .ram_dat_r (ram_dat_r),
      .ram_ack   (ram_ack)
   );

   dm_sram dm_sram_i (
      .clk       (clk),
      .rst       (rst),
      .ram_stb   (ram_stb),
      .ram_we    (ram_we),
      .ram_sel   (ram_sel),
      .ram_word  (ram_word),
      .ram_dat_w (ram_dat_w),
      .ram_dat_r (ram_dat_r),
      .ram_ack   (ram_ack)
   );

endmodule

//--- verif/dm_bus_tb.sv
`timescale 1ns/1ps
`include "dm_bus_settings.svh"

module dm_bus_tb;

   localparam int N_RAND  = 40; // random accesses per master.
   localparam int TIMEOUT = 60; // cycles any wait may last.

   logic                       clk = 1'b0;
   logic                       rst = 1'b1;
   logic [`DM_NUM_MASTERS-1:0] m_cyc = '0;
   logic [`DM_NUM_MASTERS-1:0] m_stb = '0;
   logic [`DM_NUM_MASTERS-1:0] m_we = '0;
   dm_bus_pkg::dm_sel_t        m_sel [`DM_NUM_MASTERS];
   dm_bus_pkg::dm_addr_t       m_adr [`DM_NUM_MASTERS];
   dm_bus_pkg::dm_data_t       m_dat_w [`DM_NUM_MASTERS];
   dm_bus_pkg::dm_data_t       m_dat_r;
   logic [`DM_NUM_MASTERS-1:0] m_ack;
   logic [`DM_NUM_MASTERS-1:0] m_err;

   logic [15:0]          lfsr = 16'd4441;
   logic                 st_we  [`DM_NUM_MASTERS][N_RAND]; // per master stimulus.
   dm_bus_pkg::dm_sel_t  st_sel [`DM_NUM_MASTERS][N_RAND];
   dm_bus_pkg::dm_addr_t st_adr [`DM_NUM_MASTERS][N_RAND];
   dm_bus_pkg::dm_data_t st_dat [`DM_NUM_MASTERS][N_RAND];
   int                   st_gap [`DM_NUM_MASTERS][N_RAND];
   dm_bus_pkg::dm_data_t model_mem [`DM_SRAM_WORDS];
   dm_bus_pkg::dm_sel_t  model_known [`DM_SRAM_WORDS]; // bytes written so far.
   int                   errors = 0;
   int                   accesses = 0;
   logic                 hold_phase = 1'b0; // master 1 owns the bus on purpose.
   logic                 others_go = 1'b0;
   int                   done_order [$];    // master index per completion.

   dm_bus_top dm_bus_top_i (
      .clk     (clk),
      .rst     (rst),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_sel   (m_sel),
      .m_adr   (m_adr),
      .m_dat_w (m_dat_w),
      .m_dat_r (m_dat_r),
      .m_ack   (m_ack),
      .m_err   (m_err)
   );

   always #2 clk = ~clk; // 4 ns period.

   // x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic lfsr_step();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()}; // one step per bit.
      end
      return v;
   endfunction

   // all random stimulus is drawn up front, in a fixed order.
   function automatic void make_stimulus();
      logic [31:0] word;
      for (int a = 0; a < N_RAND; a++) begin
         for (int m = 0; m < `DM_NUM_MASTERS; m++) begin
            st_gap[m][a] = 1 + int'(rand_bits(2));
            st_we[m][a]  = lfsr_step();
            st_sel[m][a] = dm_bus_pkg::dm_sel_t'(rand_bits(4));
            word         = rand_bits(5); // 32 words, shared so masters collide.
            if (rand_bits(3) == 0) begin
               // outside the window, low bits still alias onto used words.
               st_adr[m][a] = `DM_SRAM_BASE + 32'h0000_0400 + (rand_bits(14) << 10) + (word << 2);
            end else begin
               st_adr[m][a] = `DM_SRAM_BASE + (word << 2);
            end
            st_dat[m][a] = rand_bits(32);
            if (!st_we[m][a]) st_sel[m][a] = 4'hf; // reads take the full word.
         end
      end
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #0.5; // drive slot.
      end
   endtask

   // judge one completed access against the model, then apply a write.
   task automatic check_response(input int m, input logic we, input dm_bus_pkg::dm_sel_t sel,
                                 input dm_bus_pkg::dm_addr_t adr,
                                 input dm_bus_pkg::dm_data_t dat);
      logic                 hit;
      logic [7:0]           w;
      dm_bus_pkg::dm_addr_t word_idx;
      dm_bus_pkg::dm_data_t mask;
      word_idx = (adr - `DM_SRAM_BASE) >> 2; // words counted from the window base.
      hit      = word_idx < `DM_SRAM_WORDS;
      w        = word_idx[7:0];
      mask     = '0;
      for (int b = 0; b < `DM_DW / 8; b++) begin
         if (model_known[w][b]) mask[b*8 +: 8] = 8'hff; // unwritten bytes are don't care.
      end
      accesses++;
      assert (m_ack[m] === hit) else begin
         errors++;
         $display("FAILED t=%0t m_ack[%0d] got %b expected %b", $time, m, m_ack[m], hit);
      end
      assert (m_err[m] === !hit) else begin
         errors++;
         $display("FAILED t=%0t m_err[%0d] got %b expected %b", $time, m, m_err[m], !hit);
      end
      if (hit && !we) begin
         assert ((m_dat_r & mask) === (model_mem[w] & mask)) else begin
            errors++;
            $display("FAILED t=%0t m_dat_r adr %h got %h expected %h", $time, adr,
                     m_dat_r & mask, model_mem[w] & mask);
         end
      end
      if (hit && we) begin
         for (int b = 0; b < `DM_DW / 8; b++) begin
            if (sel[b]) begin
               model_mem[w][b*8 +: 8] = dat[b*8 +: 8];
               model_known[w][b]      = 1'b1;
            end
         end
      end
   endtask

   // one classic access, entered in a drive slot.
   task automatic do_access(input int m, input logic we, input dm_bus_pkg::dm_sel_t sel,
                            input dm_bus_pkg::dm_addr_t adr, input dm_bus_pkg::dm_data_t dat,
                            input logic keep_cyc);
      int   wait_cycles;
      logic got;
      wait_cycles = 0;
      got         = 1'b0;
      m_cyc[m]    = 1'b1;
      m_stb[m]    = 1'b1;
      m_we[m]     = we;
      m_sel[m]    = sel;
      m_adr[m]    = adr;
      m_dat_w[m]  = dat;
      while (!got && wait_cycles < TIMEOUT) begin
         @(negedge clk); // responses are stable mid cycle.
         wait_cycles++;
         got = ((m_ack[m] | m_err[m]) === 1'b1);
      end
      assert (got) else begin
         errors++;
         $display("master %0d got no ack or err within %0d cycles at t=%0t", m, TIMEOUT, $time);
      end
      if (got) begin
         done_order.push_back(m);
         check_response(m, we, sel, adr, dat);
      end
      idle_cycles(1);
      m_stb[m] = 1'b0;
      m_cyc[m] = keep_cyc; // held cyc keeps the grant.
   endtask

   task automatic run_random(input int m);
      for (int a = 0; a < N_RAND; a++) begin
         idle_cycles(st_gap[m][a]); // gap of at least one cycle.
         do_access(m, st_we[m][a], st_sel[m][a], st_adr[m][a], st_dat[m][a], 1'b0);
      end
   endtask

   // bus wide response rules.
   always @(negedge clk) begin
      if (!rst) begin
         assert ($countones(m_ack | m_err) <= 1) else begin
            errors++;
            $display("more than one master got a response at t=%0t", $time);
         end
         assert (((m_ack | m_err) & ~m_cyc) == '0) else begin
            errors++;
            $display("a master got a response outside its cycle at t=%0t", $time);
         end
         assert (!hold_phase || ((m_ack | m_err) & 3'b101) == '0) else begin
            errors++;
            $display("master 0 or 2 was answered while master 1 held the bus at t=%0t", $time);
         end
      end
   end

   initial begin
      int wait_cycles;
      for (int m = 0; m < `DM_NUM_MASTERS; m++) begin
         m_sel[m]   = '0;
         m_adr[m]   = '0;
         m_dat_w[m] = '0;
      end
      for (int w = 0; w < `DM_SRAM_WORDS; w++) begin
         model_mem[w]   = '0;
         model_known[w] = '0;
      end
      make_stimulus();
      repeat (4) @(posedge clk);
      #0.5;
      rst = 1'b0;
      @(negedge clk);
      assert (m_ack === '0 && m_err === '0) else begin
         errors++;
         $display("FAILED t=%0t m_ack got %b expected 000, m_err got %b expected 000",
                  $time, m_ack, m_err);
      end
      idle_cycles(1);
      // all three at once, grant starts at 0.
      fork
         do_access(0, 1'b1, 4'hf, `DM_SRAM_BASE, 32'h1111_0000, 1'b0);
         do_access(1, 1'b1, 4'hf, `DM_SRAM_BASE + 32'h4, 32'h2222_0001, 1'b0);
         do_access(2, 1'b0, 4'hf, `DM_SRAM_BASE, 32'h0, 1'b0);
      join
      assert (done_order.size() == 3 && done_order[0] == 0 && done_order[1] == 1
              && done_order[2] == 2) else begin
         errors++;
         $display("completion order after reset was not master 0, 1, 2");
      end
      idle_cycles(2);
      fork
         begin
            do_access(1, 1'b1, 4'b0011, `DM_SRAM_BASE + 32'h8, 32'ha5a5_5a5a, 1'b1);
            hold_phase = 1'b1;
            others_go  = 1'b1;
            for (int k = 0; k < 3; k++) begin
               idle_cycles(1); // stb low between accesses, cyc stays up.
               do_access(1, k[0], 4'hf, `DM_SRAM_BASE + 32'h8, 32'h0bad_f00d + k, k != 2);
            end
            hold_phase = 1'b0;
         end
         begin
            wait_cycles = 0;
            while (!others_go && wait_cycles < TIMEOUT) begin
               @(posedge clk);
               wait_cycles++;
            end
            #0.5;
            assert (others_go) else begin
               errors++;
               $display("master 1 never took the bus for its held cycle");
            end
            fork
               do_access(0, 1'b0, 4'hf, `DM_SRAM_BASE + 32'h8, 32'h0, 1'b0);
               do_access(2, 1'b0, 4'hf, `DM_SRAM_BASE + 32'h4, 32'h0, 1'b0);
            join
         end
      join
      idle_cycles(2);
      fork
         run_random(0);
         run_random(1);
         run_random(2);
      join
      idle_cycles(4);
      $display("accesses checked %0d, errors %0d", accesses, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+include
hw/dm_bus_pkg.sv
hw/dm_bus_arbiter.sv
hw/dm_bus_mux.sv
hw/dm_bus_decode.sv
hw/dm_sram.sv
hw/dm_bus_top.sv
verif/dm_bus_tb.sv

//--- run.sh
#!/bin/sh
# build and run the data memory bus testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dm_bus_tb -f files.f -o dm_bus_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dm_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
   echo "simulation log has no result line"
   exit 1
fi
exit 0
